/* hdl/box_pkg.sv */
`default_nettype none

package box_pkg;

    localparam int PIX_W  = 8;   // One colour channel
    localparam int NUM_CH = 3;
    localparam int WSUM_W = 12;  // 9 * 255 = 2295
    localparam int BOX_W  = 14;  // Room for up to 4 window sums

    // Field order puts r in the top bits of the word
    typedef struct packed {
        logic [PIX_W-1:0] r;
        logic [PIX_W-1:0] g;
        logic [PIX_W-1:0] b;
    } pixel_t;

    // Row-major 3x3 neighbourhood
    // Element 0 is row r-2, column c-2; element 8 is the newest pixel; element 4 is the centre
    typedef pixel_t [8:0] window_t;

    typedef struct packed {
        logic [BOX_W-1:0] box_sum;
        logic [PIX_W-1:0] center;
    } lane_out_t;

    typedef lane_out_t [NUM_CH-1:0] lane_out_arr_t;  // Index 0 is the r lane

endpackage

`default_nettype wire

/* hdl/window_former.sv */
`default_nettype none

module window_former import box_pkg::*; #(
    parameter int COLS = 11,
    parameter int ROWS = 11
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_valid,
    input  pixel_t  i_pixel,
    output logic    o_valid,
    output window_t o_window,
    output logic    o_row_start
);

    localparam int CW = $clog2(COLS + 1);
    localparam int RW = $clog2(ROWS + 1);

    logic [CW-1:0] col_q;
    logic [RW-1:0] row_q;
    pixel_t        line1 [COLS];  // Row r-1
    pixel_t        line2 [COLS];  // Row r-2
    pixel_t        top_px;
    pixel_t        mid_px;
    window_t       win_next;

    // Frame position wraps at the end of each row and frame
    always_ff @(posedge clk) begin
        if (rst) begin
            col_q <= '0;
            row_q <= '0;
        end else if (i_valid) begin
            if (col_q == CW'(COLS - 1)) begin
                col_q <= '0;
                row_q <= (row_q == RW'(ROWS - 1)) ? '0 : row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // Two line buffers written at the current column
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < COLS; i++) begin
                line1[i] <= '0;
                line2[i] <= '0;
            end
        end else if (i_valid) begin
            line1[col_q] <= i_pixel;
            line2[col_q] <= line1[col_q];  // Old row r-1 moves down
        end
    end

    // Rows above the frame read as zero
    assign top_px = (row_q >= RW'(2)) ? line2[col_q] : '0;
    assign mid_px = (row_q >= RW'(1)) ? line1[col_q] : '0;

    // Shift the window one column left and zero columns left of the frame
    always_comb begin
        win_next[2] = top_px;
        win_next[5] = mid_px;
        win_next[8] = i_pixel;
        win_next[1] = (col_q >= CW'(1)) ? o_window[2] : '0;
        win_next[4] = (col_q >= CW'(1)) ? o_window[5] : '0;
        win_next[7] = (col_q >= CW'(1)) ? o_window[8] : '0;
        win_next[0] = (col_q >= CW'(2)) ? o_window[1] : '0;
        win_next[3] = (col_q >= CW'(2)) ? o_window[4] : '0;
        win_next[6] = (col_q >= CW'(2)) ? o_window[7] : '0;
    end

    // The window register also holds the previous columns
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_window <= win_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid     <= 1'b0;
            o_row_start <= 1'b0;
        end else begin
            o_valid     <= i_valid;
            o_row_start <= i_valid && (col_q == '0);
        end
    end

    a_col_in_range: assert property (
        @(posedge clk) disable iff (rst) col_q < CW'(COLS)
    );

endmodule

`default_nettype wire

/* hdl/box_sum_lane.sv */
`default_nettype none

module box_sum_lane import box_pkg::*; #(
    parameter int RUN = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_valid,
    input  logic                  i_row_start,
    input  logic [8:0][PIX_W-1:0] i_taps,
    output logic                  o_valid,
    output lane_out_t             o_result
);

    localparam int MAX_WSUM = 9 * ((1 << PIX_W) - 1);

    logic [2:0]                vld_q;   // Valid for stages 1 to 3
    logic [2:0]                rs_q;    // Row start for stages 1 to 3
    logic [3:0][PIX_W:0]       pair_q;
    logic [1:0][PIX_W+1:0]     quad_q;
    logic [WSUM_W-1:0]         wsum_q;
    logic [1:0][PIX_W-1:0]     tap8_q;
    logic [3:0][PIX_W-1:0]     ctr_q;   // Centre tap, one entry per stage
    logic [RUN-1:0][WSUM_W-1:0] hist_q;
    logic [BOX_W-1:0]          box_q;
    logic [BOX_W-1:0]          box_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q   <= '0;
            rs_q    <= '0;
            o_valid <= 1'b0;
        end else begin
            vld_q   <= {vld_q[1:0], i_valid};
            rs_q    <= {rs_q[1:0], i_row_start};
            o_valid <= vld_q[2];
        end
    end

    // Adder tree advances every cycle
    always_ff @(posedge clk) begin
        pair_q[0] <= {1'b0, i_taps[0]} + {1'b0, i_taps[1]};
        pair_q[1] <= {1'b0, i_taps[2]} + {1'b0, i_taps[3]};
        pair_q[2] <= {1'b0, i_taps[4]} + {1'b0, i_taps[5]};
        pair_q[3] <= {1'b0, i_taps[6]} + {1'b0, i_taps[7]};
        tap8_q[0] <= i_taps[8];

        quad_q[0] <= {1'b0, pair_q[0]} + {1'b0, pair_q[1]};
        quad_q[1] <= {1'b0, pair_q[2]} + {1'b0, pair_q[3]};
        tap8_q[1] <= tap8_q[0];

        // Eight-sum plus the last tap of the newest row
        wsum_q <= WSUM_W'(quad_q[0]) + WSUM_W'(quad_q[1]) + WSUM_W'(tap8_q[1]);
    end

    // Centre pixel follows the window sum down the pipe
    always_ff @(posedge clk) begin
        ctr_q[0] <= i_taps[4];
        ctr_q[1] <= ctr_q[0];
        ctr_q[2] <= ctr_q[1];
        ctr_q[3] <= ctr_q[2];
    end

    // Oldest history entry drops out of the box
    assign box_next = box_q + BOX_W'(wsum_q) - BOX_W'(hist_q[RUN-1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            box_q  <= '0;
            hist_q <= '0;
        end else if (vld_q[2]) begin
            for (int i = RUN - 1; i > 0; i--) begin
                hist_q[i] <= rs_q[2] ? '0 : hist_q[i-1];
            end
            hist_q[0] <= wsum_q;
            box_q     <= rs_q[2] ? BOX_W'(wsum_q) : box_next;  // Reload at column 0
        end
    end

    assign o_result = '{box_sum: box_q, center: ctr_q[3]};

    // Holds only if the history and the box sum stay in step
    a_box_bound: assert property (
        @(posedge clk) disable iff (rst) box_q <= BOX_W'(RUN * MAX_WSUM)
    );

endmodule

`default_nettype wire

/* hdl/contrast_combiner.sv */
`default_nettype none

module contrast_combiner import box_pkg::*; #(
    parameter int RUN = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  lane_out_arr_t     i_lanes,
    output logic              o_valid,
    output logic [NUM_CH-1:0] o_flags,
    output lane_out_arr_t     o_lanes
);

    localparam int AREA = 3 * (RUN + 2);  // Box area used as scale

    logic [NUM_CH-1:0][BOX_W-1:0] scaled;
    logic [NUM_CH-1:0]            flag_next;

    for (genvar k = 0; k < NUM_CH; k++) begin : g_cmp
        assign scaled[k]    = BOX_W'(i_lanes[k].center) * BOX_W'(AREA);
        assign flag_next[k] = scaled[k] > i_lanes[k].box_sum;  // Strictly brighter
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_flags <= flag_next;
        o_lanes <= i_lanes;
    end

    // Valid must settle once reset has cleared every stage upstream
    a_valid_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(o_valid)
    );

endmodule

`default_nettype wire

/* hdl/box_filter_top.sv */
`default_nettype none

module box_filter_top import box_pkg::*; #(
    parameter int COLS = 11,
    parameter int ROWS = 11,
    parameter int RUN  = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  pixel_t            i_pixel,
    output logic              o_valid,
    output logic [NUM_CH-1:0] o_flags,
    output lane_out_arr_t     o_lanes
);

    logic              w_valid;
    window_t           w_window;
    logic              w_row_start;
    logic [NUM_CH-1:0] l_valid;
    lane_out_arr_t     l_result;

    window_former #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) u_window (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (i_valid),
        .i_pixel     (i_pixel),
        .o_valid     (w_valid),
        .o_window    (w_window),
        .o_row_start (w_row_start)
    );

    for (genvar k = 0; k < NUM_CH; k++) begin : g_lane
        logic [8:0][PIX_W-1:0] taps;

        // Channel k of every window position
        for (genvar j = 0; j < 9; j++) begin : g_tap
            assign taps[j] = (k == 0) ? w_window[j].r :
                             (k == 1) ? w_window[j].g : w_window[j].b;
        end

        box_sum_lane #(
            .RUN (RUN)
        ) u_lane (
            .clk         (clk),
            .rst         (rst),
            .i_valid     (w_valid),
            .i_row_start (w_row_start),
            .i_taps      (taps),
            .o_valid     (l_valid[k]),
            .o_result    (l_result[k])
        );
    end

    contrast_combiner #(
        .RUN (RUN)
    ) u_combiner (
        .clk     (clk),
        .rst     (rst),
        .i_valid (l_valid[0]),  // Lanes run in lockstep
        .i_lanes (l_result),
        .o_valid (o_valid),
        .o_flags (o_flags),
        .o_lanes (o_lanes)
    );

endmodule

`default_nettype wire

/* dv/clk_gen.sv */
`default_nettype none

module clk_gen #(
    parameter int PERIOD = 8
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;  // First rising edge at half a period
    end

endmodule

`default_nettype wire

/* dv/box_filter_tb.sv */
`default_nettype none

module box_filter_tb import box_pkg::*; ();

    localparam int COLS            = 11;
    localparam int ROWS            = 11;
    localparam int RUN             = 4;
    localparam int CLK_PERIOD      = 8;
    localparam int LATENCY         = 6;
    localparam int FRAME_PIX       = COLS * ROWS;
    localparam int NUM_FRAMES      = 5;
    localparam int TOTAL_PIX       = NUM_FRAMES * FRAME_PIX;
    localparam int WATCHDOG_CYCLES = 20 * TOTAL_PIX + 200;

    localparam int FILL_RANDOM = 0;
    localparam int FILL_WHITE  = 1;
    localparam int FILL_SPOT   = 2;

    localparam int     SPOT_POS = 5 * COLS + 5;
    localparam pixel_t SPOT_PX  = 24'hff0080;  // r full, g dark, b half

    typedef struct packed {
        logic [NUM_CH-1:0] flags;
        lane_out_arr_t     lanes;
    } result_t;

    logic              clk;
    logic              rst;
    logic              i_valid;
    pixel_t            i_pixel;
    logic              o_valid;
    logic [NUM_CH-1:0] o_flags;
    lane_out_arr_t     o_lanes;

    pixel_t      img_q[$];    // Every accepted pixel of all frames in a row
    result_t     exp_q[$];
    int          issue_q[$];  // Cycle count at which each pixel was driven
    int          cycle;
    logic [31:0] rng;

    clk_gen #(
        .PERIOD (CLK_PERIOD)
    ) u_clk (
        .o_clk (clk)
    );

    box_filter_top #(
        .COLS (COLS),
        .ROWS (ROWS),
        .RUN  (RUN)
    ) DUT (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .i_pixel (i_pixel),
        .o_valid (o_valid),
        .o_flags (o_flags),
        .o_lanes (o_lanes)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int channel_of(input pixel_t px, input int k);
        case (k)
            0:       return px.r;
            1:       return px.g;
            default: return px.b;
        endcase
    endfunction

    // Positions above or left of the frame read as zero
    function automatic int pixel_at(input int base, input int r, input int c, input int k);
        if (r < 0 || c < 0) begin
            return 0;
        end else begin
            return channel_of(img_q[base + r * COLS + c], k);
        end
    endfunction

    function automatic int window_sum(input int base, input int r, input int c, input int k);
        int sum;
        sum = 0;
        for (int dr = -2; dr <= 0; dr++) begin
            for (int dc = -2; dc <= 0; dc++) begin
                sum += pixel_at(base, r + dr, c + dc, k);
            end
        end
        return sum;
    endfunction

    // Expected output for the n-th accepted pixel
    function automatic result_t expected_result(input int n);
        result_t   res;
        lane_out_t lane;
        int        base;
        int        pos;
        int        r;
        int        c;
        int        box;
        int        centre;
        base = (n / FRAME_PIX) * FRAME_PIX;
        pos  = n % FRAME_PIX;
        r    = pos / COLS;
        c    = pos % COLS;
        for (int k = 0; k < NUM_CH; k++) begin
            box = 0;
            for (int j = 0; j < RUN && j <= c; j++) begin  // Box restarts at column 0
                box += window_sum(base, r, c - j, k);
            end
            centre       = pixel_at(base, r - 1, c - 1, k);
            lane.box_sum = BOX_W'(box);
            lane.center  = PIX_W'(centre);
            res.lanes[k] = lane;
            res.flags[k] = (centre * 3 * (RUN + 2)) > box;
        end
        return res;
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send_pixel(input pixel_t px, input int gap);
        i_valid = 1'b1;
        i_pixel = px;
        img_q.push_back(px);
        exp_q.push_back(expected_result(img_q.size() - 1));
        issue_q.push_back(cycle);
        @(negedge clk);
        i_valid = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic send_frame(input int fill, input bit gaps);
        pixel_t px;
        int     gap;
        for (int p = 0; p < FRAME_PIX; p++) begin
            rng = xorshift32(rng);
            case (fill)
                FILL_WHITE: px = '1;
                FILL_SPOT:  px = (p == SPOT_POS) ? SPOT_PX : pixel_t'(0);
                default:    px = rng[23:0];
            endcase
            gap = gaps ? int'(rng[25:24]) : 0;
            send_pixel(px, gap);
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Outputs settle on the rising edge and are read on the falling one
    always @(negedge clk) begin
        result_t   exp;
        lane_out_t got;
        lane_out_t want;
        int        issued;
        if (rst) begin
            check_value("o_valid", o_valid, 32'd0);
        end else if ($isunknown(o_valid)) begin
            $display("o_valid is unknown after reset at time %0t", $time);
            abort_run();
        end else if (o_valid) begin
            if (exp_q.size() == 0) begin
                $display("o_valid went high at time %0t with no pixel in flight", $time);
                abort_run();
            end else begin
                exp    = exp_q.pop_front();
                issued = issue_q.pop_front();
                check_value("o_valid latency", cycle - issued, LATENCY);
                check_value("o_flags", o_flags, exp.flags);
                for (int k = 0; k < NUM_CH; k++) begin
                    got  = o_lanes[k];
                    want = exp.lanes[k];
                    check_value($sformatf("o_lanes[%0d].box_sum", k), got.box_sum,
                                want.box_sum);
                    check_value($sformatf("o_lanes[%0d].center", k), got.center,
                                want.center);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        cycle   = 0;
        rst     = 1'b1;
        i_valid = 1'b0;
        i_pixel = '0;
        rng     = 32'd85687;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (8) @(negedge clk);  // o_valid must stay low while idle

        send_frame(FILL_RANDOM, 1'b0);  // Back to back
        send_frame(FILL_WHITE, 1'b0);   // Follows at once so the top rows are masked again
        send_frame(FILL_RANDOM, 1'b1);
        send_frame(FILL_SPOT, 1'b1);
        send_frame(FILL_RANDOM, 1'b0);

        for (int i = 0; i < 4 * LATENCY && exp_q.size() != 0; i++) begin
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("Outputs missing: %0d results never appeared", exp_q.size());
            abort_run();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
hdl/box_pkg.sv
hdl/window_former.sv
hdl/box_sum_lane.sv
hdl/contrast_combiner.sv
hdl/box_filter_top.sv
dv/clk_gen.sv
dv/box_filter_tb.sv

/* Bender.yml */
package:
  name: box_filter

sources:
  - hdl/box_pkg.sv
  - hdl/window_former.sv
  - hdl/box_sum_lane.sv
  - hdl/contrast_combiner.sv
  - hdl/box_filter_top.sv
  - target: simulation
    files:
      - dv/clk_gen.sv
      - dv/box_filter_tb.sv
